//--- dv/sift_front_cases.txt
# name, then 64 base image pixels row-major, then 16 expected half image pixels
# all values hex, one case per line
ramp 00 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F 10 11 12 13 14 15 16 17 18 19 1A 1B 1C 1D 1E 1F 20 21 22 23 24 25 26 27 28 29 2A 2B 2C 2D 2E 2F 30 31 32 33 34 35 36 37 38 39 3A 3B 3C 3D 3E 3F 04 06 08 0A 14 16 18 1A 24 26 28 2A 34 36 38 3A
all_ff FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF
checker 00 FF 00 FF 00 FF 00 FF FF 00 FF 00 FF 00 FF 00 00 FF 00 FF 00 FF 00 FF FF 00 FF 00 FF 00 FF 00 00 FF 00 FF 00 FF 00 FF FF 00 FF 00 FF 00 FF 00 00 FF 00 FF 00 FF 00 FF FF 00 FF 00 FF 00 FF 00 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F
zeros 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
arbitrary 12 34 56 78 9A BC DE F0 0F 1E 2D 3C 4B 5A 69 78 80 01 FF 7F 33 CC 55 AA 10 20 30 40 50 60 70 81 A5 5A C3 3C 96 69 E1 1E 01 02 03 04 05 06 07 08 FE DC BA 98 76 54 32 10 11 22 33 44 55 66 77 88 1C 4D 7E AB 2C 7B 6B 7C 40 41 42 43 83 72 61 50
trunc 01 01 01 01 01 01 01 01 02 02 02 02 02 02 02 02 01 01 01 01 01 01 01 01 02 02 02 02 02 02 02 02 01 01 01 01 01 01 01 01 02 02 02 02 02 02 02 02 01 01 01 01 01 01 01 01 02 02 02 02 02 02 02 02 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01

//--- project.f
logic/sift_pkg.sv
logic/uart_rx.sv
logic/frame_loader.sv
logic/pixel_ram.sv
logic/octave_downsampler.sv
logic/uart_tx.sv
logic/image_sender.sv
logic/sift_front_top.sv
dv/sift_front_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module sift_front_tb -f project.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    echo "run passed"
    exit 0
else
    echo "run failed, see sim.log"
    exit 1
fi

//--- dv/sift_front_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sift_front_tb;
    import sift_pkg::*;

    localparam int FRAME_CYCLES = 10 * CLKS_PER_BAUD;  // start, 8 data, stop

    logic clk_100mhz;
    logic sys_rst;
    logic uart_rxd;
    logic send_req;
    logic uart_txd;
    logic frame_loaded;
    logic pyramid_done;
    logic busy;

    int     frame_cnt = 0;      // frame_loaded_o pulses seen
    int     pyr_cnt = 0;        // pyramid_done_o pulses seen
    int     framing_errs = 0;   // low stop bits seen by the monitor
    int     frames_at_stop;     // frame count as the last stop bit began
    int     test_errors;
    int     total_errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     cases_run = 0;
    string  case_name;
    pixel_t pix_q[$];           // base image, row-major
    pixel_t exp_q[$];           // expected half image
    pixel_t got_q[$];           // every byte off uart_txd_o

    sift_front_top u_dut (
        .clk_100mhz     (clk_100mhz),
        .sys_rst        (sys_rst),
        .uart_rxd_i     (uart_rxd),
        .send_req_i     (send_req),
        .uart_txd_o     (uart_txd),
        .frame_loaded_o (frame_loaded),
        .pyramid_done_o (pyramid_done),
        .busy_o         (busy)
    );

    initial clk_100mhz = 1'b0;
    always #5 clk_100mhz = ~clk_100mhz;  // 100 MHz

    // strobes counted on the falling edge, well clear of dut updates
    always @(negedge clk_100mhz) begin
        if (!sys_rst && frame_loaded === 1'b1) frame_cnt++;
        if (!sys_rst && pyramid_done === 1'b1) pyr_cnt++;
    end

    // serial monitor, 8N1 at CLKS_PER_BAUD
    always begin : serial_monitor
        pixel_t rx_data;
        @(negedge clk_100mhz);
        if (!sys_rst && uart_txd === 1'b0) begin
            rx_data = '0;
            repeat (CLKS_PER_BAUD / 2) @(negedge clk_100mhz);  // middle of start bit
            repeat (PIX_BITS) begin
                repeat (CLKS_PER_BAUD) @(negedge clk_100mhz);
                rx_data = {uart_txd, rx_data[PIX_BITS-1:1]};  // lsb first
            end
            repeat (CLKS_PER_BAUD) @(negedge clk_100mhz);  // mid stop bit
            assert (uart_txd === 1'b1) else begin
                $display("framing error: stop bit low on uart_txd_o at %0t", $time);
                framing_errs++;
            end
            got_q.push_back(rx_data);
        end
    end

    task automatic tick();
        @(posedge clk_100mhz);
        #1;  // inputs move just after the edge
    endtask

    task automatic send_byte(input pixel_t value);
        pixel_t bits;
        bits = value;
        uart_rxd = 1'b0;  // start bit
        repeat (CLKS_PER_BAUD) tick();
        repeat (PIX_BITS) begin
            uart_rxd = bits[0];
            bits = bits >> 1;
            repeat (CLKS_PER_BAUD) tick();
        end
        uart_rxd = 1'b1;  // stop bit
        frames_at_stop = frame_cnt;
        repeat (CLKS_PER_BAUD) tick();
    endtask

    task automatic send_frame(input int frames_before);
        int gap;
        for (int p = 0; p < BASE_PIXELS; p++) begin
            gap = $urandom_range(20, 0);  // idle baud periods ahead of the byte
            repeat (gap * CLKS_PER_BAUD) tick();
            send_byte(pix_q[p]);
            if (p == BASE_PIXELS - 2) begin
                assert (frame_cnt == frames_before) else begin
                    $display("case %s: frame_loaded_o pulsed before the last pixel", case_name);
                    test_errors++;
                end
            end
        end
        // nothing until the 64th stop bit starts
        assert (frames_at_stop == frames_before) else begin
            $display("case %s: frame_loaded_o pulsed before the last stop bit", case_name);
            test_errors++;
        end
    endtask

    task automatic wait_pyramid(input int frames_before, input int pyrs_before);
        int waited;
        waited = 0;
        while (frame_cnt == frames_before && waited < FRAME_CYCLES) begin
            tick();
            waited++;
        end
        assert (frame_cnt != frames_before) else begin
            $display("case %s: timeout, frame_loaded_o never pulsed", case_name);
            test_errors++;
        end
        waited = 0;
        while (pyr_cnt == pyrs_before && waited < 200) begin  // about 67 cycles expected
            tick();
            waited++;
        end
        assert (pyr_cnt != pyrs_before) else begin
            $display("case %s: timeout, pyramid_done_o never pulsed", case_name);
            test_errors++;
        end
        repeat (4) tick();
        assert (frame_cnt - frames_before == 1) else begin
            $display("** Error: case %s frame_loaded_o pulses expected 1 actual %0d",
                     case_name, frame_cnt - frames_before);
            test_errors++;
        end
        assert (pyr_cnt - pyrs_before == 1) else begin
            $display("** Error: case %s pyramid_done_o pulses expected 1 actual %0d",
                     case_name, pyr_cnt - pyrs_before);
            test_errors++;
        end
    endtask

    task automatic read_back(input int pass);
        int waited;
        int first;
        int n;
        int errs_before;
        first = got_q.size();
        errs_before = framing_errs;
        send_req = 1'b1;
        tick();
        send_req = 1'b0;
        waited = 0;
        while (busy !== 1'b1 && waited < 10) begin
            tick();
            waited++;
        end
        assert (busy === 1'b1) else begin
            $display("case %s: busy_o did not rise after a send request", case_name);
            test_errors++;
        end
        repeat (3 * CLKS_PER_BAUD) tick();
        send_req = 1'b1;  // lands mid transfer, should be dropped
        tick();
        send_req = 1'b0;
        waited = 0;
        while (busy === 1'b1 && waited < 2 * HALF_PIXELS * FRAME_CYCLES) begin
            tick();
            waited++;
        end
        assert (busy === 1'b0) else begin
            $display("case %s: timeout, busy_o stayed high during readback", case_name);
            test_errors++;
        end
        repeat (2 * FRAME_CYCLES) tick();  // room for a stray byte
        n = got_q.size() - first;
        assert (n == HALF_PIXELS) else begin
            $display("** Error: case %s pass %0d byte count expected %0d actual %0d",
                     case_name, pass, HALF_PIXELS, n);
            test_errors++;
        end
        for (int i = 0; i < HALF_PIXELS && i < n; i++) begin
            assert (got_q[first + i] == exp_q[i]) else begin
                $display("** Error: case %s pass %0d pixel %0d expected %02h actual %02h",
                         case_name, pass, i, exp_q[i], got_q[first + i]);
                test_errors++;
            end
        end
        assert (framing_errs == errs_before) else begin
            $display("case %s: bad stop bits during readback pass %0d", case_name, pass);
            test_errors++;
        end
    endtask

    task automatic check_idle();
        test_errors = 0;
        assert (uart_txd === 1'b1) else begin
            $display("** Error: idle_after_reset uart_txd_o expected 1 actual %b", uart_txd);
            test_errors++;
        end
        assert (busy === 1'b0) else begin
            $display("** Error: idle_after_reset busy_o expected 0 actual %b", busy);
            test_errors++;
        end
        assert (frame_loaded === 1'b0) else begin
            $display("** Error: idle_after_reset frame_loaded_o expected 0 actual %b",
                     frame_loaded);
            test_errors++;
        end
        assert (pyramid_done === 1'b0) else begin
            $display("** Error: idle_after_reset pyramid_done_o expected 0 actual %b",
                     pyramid_done);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s (%0d errors)", name, test_errors);
        end
    endtask

    // one case per line: name, 64 pixels, 16 expected, hex
    function automatic bit read_case(input int fd);
        string tok;
        string rest;
        int    v;
        int    got;
        got = $fscanf(fd, "%s", tok);
        if (got != 1) return 1'b0;  // end of file
        if (tok.substr(0, 0) == "#") begin
            void'($fgets(rest, fd));  // column notes
            return 1'b0;
        end
        case_name = tok;
        pix_q.delete();
        exp_q.delete();
        got = 0;
        for (int i = 0; i < BASE_PIXELS + HALF_PIXELS; i++) begin
            got += $fscanf(fd, "%h", v);
            if (i < BASE_PIXELS) begin
                pix_q.push_back(pixel_t'(v));
            end else begin
                exp_q.push_back(pixel_t'(v));
            end
        end
        if (got != BASE_PIXELS + HALF_PIXELS) begin
            $display("case %s: short line in the case file, %0d values read", case_name, got);
            total_errors++;
            return 1'b0;
        end
        return 1'b1;
    endfunction

    initial begin
        int fd;
        int frames_before;
        int pyrs_before;
        void'($urandom(11425));
        sys_rst = 1'b1;
        uart_rxd = 1'b1;  // line idles high
        send_req = 1'b0;
        repeat (8) tick();
        sys_rst = 1'b0;
        tick();
        check_idle();
        finish_test("idle_after_reset");

        fd = $fopen("dv/sift_front_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open dv/sift_front_cases.txt");
            total_errors++;
        end else begin
            while (!$feof(fd)) begin
                if (read_case(fd)) begin
                    test_errors = 0;
                    frames_before = frame_cnt;
                    pyrs_before = pyr_cnt;
                    send_frame(frames_before);  // no reset between frames
                    wait_pyramid(frames_before, pyrs_before);
                    read_back(1);
                    read_back(2);  // resend, same bytes
                    finish_test(case_name);
                    cases_run++;
                end
            end
            $fclose(fd);
        end

        $display("tests %0d, failed %0d, errors %0d, file cases %0d",
                 tests_run, tests_failed, total_errors, cases_run);
        if (total_errors == 0 && tests_failed == 0 && cases_run > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/sift_front_top.sv
`timescale 1ns/1ps
`default_nettype none

module sift_front_top (
    input  wire logic clk_100mhz,
    input  wire logic sys_rst,
    input  wire logic uart_rxd_i,
    input  wire logic send_req_i,
    output logic      uart_txd_o,
    output logic      frame_loaded_o,
    output logic      pyramid_done_o,
    output logic      busy_o
);
    import sift_pkg::*;

    rx_byte_t   rx_byte;
    base_wr_t   base_wr;
    base_addr_t base_rd_addr;
    pixel_t     base_rd_data;
    half_wr_t   half_wr;
    half_addr_t half_rd_addr;
    pixel_t     half_rd_data;
    logic       tx_start;
    pixel_t     tx_data;
    logic       tx_ready;

    uart_rx u_uart_rx (
        .clk_100mhz (clk_100mhz),
        .sys_rst    (sys_rst),
        .rxd_i      (uart_rxd_i),
        .rx_byte_o  (rx_byte)
    );

    frame_loader u_frame_loader (
        .clk_100mhz   (clk_100mhz),
        .sys_rst      (sys_rst),
        .rx_byte_i    (rx_byte),
        .base_wr_o    (base_wr),
        .frame_done_o (frame_loaded_o)  // also kicks the downsampler
    );

    // full size image
    pixel_ram #(.DEPTH(BASE_PIXELS), .ADDR_BITS(BASE_ADDR_BITS)) u_base_ram (
        .clk_100mhz (clk_100mhz),
        .wr_en_i    (base_wr.en),
        .wr_addr_i  (base_wr.addr),
        .wr_data_i  (base_wr.data),
        .rd_addr_i  (base_rd_addr),
        .rd_data_o  (base_rd_data)
    );

    octave_downsampler u_downsampler (
        .clk_100mhz     (clk_100mhz),
        .sys_rst        (sys_rst),
        .frame_done_i   (frame_loaded_o),
        .base_rd_addr_o (base_rd_addr),
        .base_rd_data_i (base_rd_data),
        .half_wr_o      (half_wr),
        .pyr_done_o     (pyramid_done_o)
    );

    // second octave, 4x4
    pixel_ram #(.DEPTH(HALF_PIXELS), .ADDR_BITS(HALF_ADDR_BITS)) u_half_ram (
        .clk_100mhz (clk_100mhz),
        .wr_en_i    (half_wr.en),
        .wr_addr_i  (half_wr.addr),
        .wr_data_i  (half_wr.data),
        .rd_addr_i  (half_rd_addr),
        .rd_data_o  (half_rd_data)
    );

    image_sender u_image_sender (
        .clk_100mhz     (clk_100mhz),
        .sys_rst        (sys_rst),
        .send_req_i     (send_req_i),
        .half_rd_addr_o (half_rd_addr),
        .half_rd_data_i (half_rd_data),
        .tx_start_o     (tx_start),
        .tx_data_o      (tx_data),
        .tx_ready_i     (tx_ready),
        .busy_o         (busy_o)
    );

    uart_tx u_uart_tx (
        .clk_100mhz (clk_100mhz),
        .sys_rst    (sys_rst),
        .start_i    (tx_start),
        .data_i     (tx_data),
        .ready_o    (tx_ready),
        .txd_o      (uart_txd_o)
    );

endmodule

`default_nettype wire

//--- logic/image_sender.sv
`timescale 1ns/1ps
`default_nettype none

module image_sender (
    input  wire logic              clk_100mhz,
    input  wire logic              sys_rst,
    input  wire logic              send_req_i,
    output sift_pkg::half_addr_t   half_rd_addr_o,
    input  wire sift_pkg::pixel_t  half_rd_data_i,
    output logic                   tx_start_o,
    output sift_pkg::pixel_t       tx_data_o,
    input  wire logic              tx_ready_i,
    output logic                   busy_o
);
    import sift_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        WAIT_TX,
        NEXT,
        FINISH
    } snd_state_t;

    snd_state_t state;
    half_addr_t rd_addr;

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            state      <= IDLE;
            rd_addr    <= '0;
            tx_start_o <= 1'b0;
            busy_o     <= 1'b0;
        end else begin
            tx_start_o <= 1'b0;
            case (state)
                IDLE: begin
                    if (send_req_i) begin  // requests while busy fall through
                        rd_addr <= '0;
                        busy_o  <= 1'b1;
                        state   <= FETCH;
                    end
                end
                FETCH: state <= WAIT_TX;  // ram read in flight
                WAIT_TX: begin
                    if (tx_ready_i) begin
                        tx_start_o <= 1'b1;
                        state      <= NEXT;
                    end
                end
                NEXT: begin
                    // tx takes the start here, ready drops next cycle
                    if (rd_addr == half_addr_t'(HALF_PIXELS - 1)) begin
                        state <= FINISH;
                    end else begin
                        rd_addr <= rd_addr + 1'b1;
                        state   <= FETCH;
                    end
                end
                FINISH: begin
                    if (tx_ready_i) begin  // last byte fully on the line
                        busy_o <= 1'b0;
                        state  <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // byte travels with the start strobe
    always_ff @(posedge clk_100mhz) begin
        if (state == WAIT_TX && tx_ready_i) tx_data_o <= half_rd_data_i;
    end

    assign half_rd_addr_o = rd_addr;

endmodule

`default_nettype wire

//--- logic/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire logic             clk_100mhz,
    input  wire logic             sys_rst,
    input  wire logic             start_i,
    input  wire sift_pkg::pixel_t data_i,
    output logic                  ready_o,
    output logic                  txd_o
);
    import sift_pkg::*;

    logic                busy;
    baud_cnt_t           baud_cnt;
    logic [3:0]          bit_cnt;    // bit periods finished
    logic [PIX_BITS:0]   shift_q;    // {stop, data} waiting behind the start bit

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            busy     <= 1'b0;
            txd_o    <= 1'b1;  // line idles high
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!busy) begin
            if (start_i) begin
                busy     <= 1'b1;
                txd_o    <= 1'b0;  // start bit
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else begin
            if (baud_cnt == baud_cnt_t'(CLKS_PER_BAUD - 1)) begin
                baud_cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    busy <= 1'b0;  // end of stop bit, 10 periods total
                end else begin
                    txd_o   <= shift_q[0];
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    // data lsb first, stop bit last
    always_ff @(posedge clk_100mhz) begin
        if (!busy && start_i) begin
            shift_q <= {1'b1, data_i};
        end else if (busy && baud_cnt == baud_cnt_t'(CLKS_PER_BAUD - 1)) begin
            shift_q <= {1'b1, shift_q[PIX_BITS:1]};
        end
    end

    assign ready_o = !busy;

    // the sender has to wait for ready, a dropped byte would go unnoticed
    a_start_when_ready: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
        start_i |-> ready_o);

endmodule

`default_nettype wire

//--- logic/octave_downsampler.sv
`timescale 1ns/1ps
`default_nettype none

module octave_downsampler (
    input  wire logic              clk_100mhz,
    input  wire logic              sys_rst,
    input  wire logic              frame_done_i,
    output sift_pkg::base_addr_t   base_rd_addr_o,
    input  wire sift_pkg::pixel_t  base_rd_data_i,
    output sift_pkg::half_wr_t     half_wr_o,
    output logic                   pyr_done_o
);
    import sift_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        DRAIN
    } ds_state_t;

    typedef logic [PIX_BITS+1:0] sum_t;  // room for four pixels

    ds_state_t  state;
    half_addr_t rd_blk;    // output pixel being read
    logic [1:0] rd_sub;    // {dy, dx} inside the 2x2 block
    logic       vld_q;     // read issued last cycle
    logic [1:0] sub_q;
    half_addr_t blk_q;
    sum_t       acc;
    sum_t       sum;
    logic       wr_en;
    half_addr_t wr_addr;
    pixel_t     wr_data;

    // block (hy, hx) covers base rows 2hy..2hy+1 and cols 2hx..2hx+1
    always_comb begin
        int row;
        int col;
        row = 2 * (int'(rd_blk) / HALF_W) + int'(rd_sub[1]);
        col = 2 * (int'(rd_blk) % HALF_W) + int'(rd_sub[0]);
        base_rd_addr_o = base_addr_t'(row * IMG_W + col);
    end

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            state      <= IDLE;
            rd_blk     <= '0;
            rd_sub     <= '0;
            pyr_done_o <= 1'b0;
        end else begin
            pyr_done_o <= 1'b0;
            case (state)
                IDLE: begin
                    rd_blk <= '0;
                    rd_sub <= '0;
                    if (frame_done_i) state <= READ;
                end
                READ: begin
                    // one read per cycle so the next block starts while the last one sums
                    rd_sub <= rd_sub + 1'b1;
                    if (rd_sub == 2'd3) rd_blk <= rd_blk + 1'b1;
                    if (rd_sub == 2'd3 && rd_blk == half_addr_t'(HALF_PIXELS - 1)) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (wr_en && wr_addr == half_addr_t'(HALF_PIXELS - 1)) begin
                        pyr_done_o <= 1'b1;  // cycle after the 16th write
                        state      <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // accumulator runs one cycle behind the read addresses
    assign sum = acc + sum_t'(base_rd_data_i);

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            vld_q <= 1'b0;
            wr_en <= 1'b0;
        end else begin
            vld_q <= (state == READ);
            wr_en <= vld_q && (sub_q == 2'd3);  // fourth pixel in
        end
    end

    always_ff @(posedge clk_100mhz) begin
        sub_q <= rd_sub;
        blk_q <= rd_blk;
        if (vld_q) begin
            acc     <= (sub_q == 2'd0) ? sum_t'(base_rd_data_i) : sum;
            wr_addr <= blk_q;
            wr_data <= sum[PIX_BITS+1:2];  // divide by 4 and truncate
        end
    end

    assign half_wr_o = '{en: wr_en, addr: wr_addr, data: wr_data};

    // loader must not finish a new frame while the old one is still being read
    a_no_done_busy: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
        frame_done_i |-> (state == IDLE));

endmodule

`default_nettype wire

//--- logic/pixel_ram.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_ram #(
    parameter int DEPTH     = sift_pkg::BASE_PIXELS,
    parameter int ADDR_BITS = sift_pkg::BASE_ADDR_BITS
) (
    input  wire logic                 clk_100mhz,
    input  wire logic                 wr_en_i,
    input  wire logic [ADDR_BITS-1:0] wr_addr_i,
    input  wire sift_pkg::pixel_t     wr_data_i,
    input  wire logic [ADDR_BITS-1:0] rd_addr_i,
    output sift_pkg::pixel_t          rd_data_o
);
    import sift_pkg::*;

    pixel_t mem [DEPTH];  // maps onto block ram

    // read-first, a same-address write shows up on the next read
    always_ff @(posedge clk_100mhz) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        rd_data_o <= mem[rd_addr_i];  // one cycle read latency
    end

endmodule

`default_nettype wire

//--- logic/frame_loader.sv
`timescale 1ns/1ps
`default_nettype none

module frame_loader (
    input  wire logic          clk_100mhz,
    input  wire logic          sys_rst,
    input  wire sift_pkg::rx_byte_t rx_byte_i,
    output sift_pkg::base_wr_t base_wr_o,
    output logic               frame_done_o
);
    import sift_pkg::*;

    base_addr_t pix_cnt;   // next pixel slot in row-major order
    logic       wr_en;
    base_addr_t wr_addr;
    pixel_t     wr_data;

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            pix_cnt      <= '0;
            wr_en        <= 1'b0;
            frame_done_o <= 1'b0;
        end else begin
            wr_en        <= rx_byte_i.valid;
            frame_done_o <= 1'b0;
            if (rx_byte_i.valid) begin
                pix_cnt <= pix_cnt + 1'b1;  // wraps to 0 after pixel 63
                // flag goes out alongside the last write
                frame_done_o <= (pix_cnt == base_addr_t'(BASE_PIXELS - 1));
            end
        end
    end

    // payload only meaningful with wr_en
    always_ff @(posedge clk_100mhz) begin
        if (rx_byte_i.valid) begin
            wr_addr <= pix_cnt;
            wr_data <= rx_byte_i.data;
        end
    end

    assign base_wr_o = '{en: wr_en, addr: wr_addr, data: wr_data};

    // receiver strobe lasts one cycle so each byte takes one pixel slot
    a_rx_single_strobe: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
        rx_byte_i.valid |=> !rx_byte_i.valid);

endmodule

`default_nettype wire

//--- logic/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  wire logic         clk_100mhz,
    input  wire logic         sys_rst,
    input  wire logic         rxd_i,
    output sift_pkg::rx_byte_t rx_byte_o
);
    import sift_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } rx_state_t;

    rx_state_t state;
    logic      rxd_meta;
    logic      rxd_sync;
    baud_cnt_t baud_cnt;
    logic [2:0] bit_cnt;
    pixel_t    shift_q;   // lsb arrives first
    logic      byte_vld;

    // line is asynchronous to us
    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd_i;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            state    <= IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            byte_vld <= 1'b0;
        end else begin
            byte_vld <= 1'b0;  // strobe only
            case (state)
                IDLE: begin
                    baud_cnt <= '0;
                    if (!rxd_sync) state <= START;  // falling edge of start bit
                end
                START: begin
                    // half a bit in, check start bit is still low
                    if (baud_cnt == baud_cnt_t'(CLKS_PER_BAUD / 2 - 1)) begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rxd_sync ? IDLE : DATA;  // glitch, back off
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                DATA: begin
                    if (baud_cnt == baud_cnt_t'(CLKS_PER_BAUD - 1)) begin
                        baud_cnt <= '0;
                        shift_q  <= {rxd_sync, shift_q[PIX_BITS-1:1]};  // mid-bit sample
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= STOP;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                STOP: begin
                    if (baud_cnt == baud_cnt_t'(CLKS_PER_BAUD - 1)) begin
                        byte_vld <= rxd_sync;  // framing error drops the byte
                        state    <= IDLE;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign rx_byte_o.valid = byte_vld;
    assign rx_byte_o.data  = shift_q;  // holds until the next frame shifts in

endmodule

`default_nettype wire

//--- logic/sift_pkg.sv
`default_nettype none

package sift_pkg;

    // base image geometry, greyscale
    localparam int PIX_BITS    = 8;
    localparam int IMG_W       = 8;
    localparam int IMG_H       = 8;
    localparam int BASE_PIXELS = IMG_W * IMG_H;

    // first octave is half size in each axis
    localparam int HALF_W      = IMG_W / 2;
    localparam int HALF_PIXELS = HALF_W * (IMG_H / 2);

    localparam int BASE_ADDR_BITS = $clog2(BASE_PIXELS);  // 6
    localparam int HALF_ADDR_BITS = $clog2(HALF_PIXELS);  // 4

    localparam int CLKS_PER_BAUD = 50;  // 2 Mbaud off the 100 MHz clock

    typedef logic [PIX_BITS-1:0]              pixel_t;
    typedef logic [BASE_ADDR_BITS-1:0]        base_addr_t;
    typedef logic [HALF_ADDR_BITS-1:0]        half_addr_t;
    typedef logic [$clog2(CLKS_PER_BAUD)-1:0] baud_cnt_t;  // bit timer for both uarts

    // one received byte, valid is a single cycle strobe
    typedef struct packed {
        logic   valid;
        pixel_t data;
    } rx_byte_t;

    // write into the base image buffer
    typedef struct packed {
        logic       en;
        base_addr_t addr;
        pixel_t     data;
    } base_wr_t;

    // write into the half image buffer
    typedef struct packed {
        logic       en;
        half_addr_t addr;
        pixel_t     data;
    } half_wr_t;

endpackage

`default_nettype wire
